// ==== run.sh ====
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f \
  --top-module decode_stage_tb -o decode_stage_sim || exit 1
out="$(./obj_dir/decode_stage_sim)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Simulation passed' && exit 0 || exit 1

// ==== source/dec_ctrl_pkg.sv ====
// Control side of the decode stage: decoded control struct and stage FSM states
// Shared by the sub-decoders, the merge logic, the FSM and the top level

package dec_ctrl_pkg;
  import rv_isa_pkg::*;

  // One decoded instruction, as handed to execute
  typedef struct packed {
    logic      illegal_insn;                       // No decoder matched
    logic      alu_en;
    alu_op_e   alu_op;
    logic      mul_en;
    mul_op_e   mul_op;
    logic      div_en;
    div_op_e   div_op;
    logic      lsu_en;                             // Load or store
    logic      lsu_we;                             // Store
    lsu_size_e lsu_size;
    logic      lsu_sext;                           // Sign extend load data
    logic      rf_we;
    logic [1:0] rf_re;                             // [0] rs1 read, [1] rs2 read
    logic      sys_ecall_insn;
    logic      sys_ebrk_insn;
    logic      sys_mret_insn;
    logic      sys_wfi_insn;
    logic      sys_fencei_insn;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
  } decoder_ctrl_t;

  // Result of a decoder that did not recognize the word
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL = '{
    illegal_insn : 1'b1,
    alu_op       : ALU_ADD,
    mul_op       : MUL_OP_MUL,
    div_op       : DIV_OP_DIV,
    lsu_size     : LSU_BYTE,
    default      : '0
  };

  // Fetch handshake, then execute handshake, one instruction at a time
  typedef enum logic [1:0] {
    S_IDLE,                                        // Waiting for a fetch request
    S_FETCH_ACK,                                   // Ack high, waiting for req to drop
    S_ISSUE,                                       // dec_req_o high, waiting for ack
    S_ISSUE_REL                                    // Waiting for execute ack to drop
  } stage_state_e;

endpackage

// ==== source/decode_ctrl_fsm.sv ====
// Control FSM of the decode stage: runs the fetch and execute four-phase handshakes
// and pulses the capture, issue and count strobes for the top level

module decode_ctrl_fsm import dec_ctrl_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,                            // Synchronous, active low
  input  logic instr_req_i,                        // Fetch request
  input  logic dec_ack_i,                          // Execute acknowledge
  output logic instr_ack_o,                        // Fetch acknowledge
  output logic dec_req_o,                          // Execute request
  output logic capture_o,                          // Load instruction register
  output logic issue_o,                            // Load output register
  output logic count_o                             // Issue completed
);

  stage_state_e state_q;
  stage_state_e state_d;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (instr_req_i) state_d = S_FETCH_ACK;
      end
      S_FETCH_ACK: begin
        if (!instr_req_i) state_d = S_ISSUE;       // Fetch released, issue now
      end
      S_ISSUE: begin
        if (dec_ack_i) state_d = S_ISSUE_REL;
      end
      S_ISSUE_REL: begin
        if (!dec_ack_i) state_d = S_IDLE;          // Next fetch may be taken
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Handshake outputs straight from the state register
  assign instr_ack_o = (state_q == S_FETCH_ACK);
  assign dec_req_o   = (state_q == S_ISSUE);

  // Strobes, one per transition
  assign capture_o = (state_q == S_IDLE) && instr_req_i;
  assign issue_o   = (state_q == S_FETCH_ACK) && !instr_req_i;
  assign count_o   = (state_q == S_ISSUE) && dec_ack_i;

endmodule

// ==== source/decode_stage.sv ====
// Decode stage top: fetch handshake in, decoded control out over a second handshake
// Holds one instruction in flight and counts the legal ones it issues

module decode_stage import rv_isa_pkg::*, dec_ctrl_pkg::*; #(
  parameter bit          M_EXT_EN = 1'b1,          // Decode RV32M
  parameter int unsigned COUNT_W  = COUNT_W_DEF    // Issue counter width
) (
  input  logic          clk_i,
  input  logic          rst_n_i,                   // Synchronous, active low
  input  logic          instr_req_i,
  input  instr_t        instr_i,
  input  logic          kill_i,                    // Squash the offered instruction
  input  logic          dec_ack_i,
  output logic          instr_ack_o,
  output logic          dec_req_o,
  output decoder_ctrl_t dec_o,                     // Stable until the next capture
  output count_t        issued_o                   // Legal instructions issued
);

  instr_t        instr_q;                          // Instruction register
  logic          kill_q;
  decoder_ctrl_t dec_ctrl;                         // Decoder result
  decoder_ctrl_t dec_q;                            // Output register
  logic          dec_kill_q;                       // Kill bit of the issued instruction
  logic          capture;
  logic          issue;
  logic          count;
  logic          legal;

  ////////////////////////////////////////////////////////////////////////////
  // Payload registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (capture) begin
      instr_q <= instr_i;
      kill_q  <= kill_i;
    end
    if (issue) begin
      dec_q      <= dec_ctrl;
      dec_kill_q <= kill_q;
    end
  end

  decoder #(
    .M_EXT_EN ( M_EXT_EN )
  ) decoder_i (
    .instr_i ( instr_q  ),
    .kill_i  ( kill_q   ),
    .ctrl_o  ( dec_ctrl )
  );

  decode_ctrl_fsm decode_ctrl_fsm_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .instr_req_i ( instr_req_i ),
    .dec_ack_i   ( dec_ack_i   ),
    .instr_ack_o ( instr_ack_o ),
    .dec_req_o   ( dec_req_o   ),
    .capture_o   ( capture     ),
    .issue_o     ( issue       ),
    .count_o     ( count       )
  );

  // Kill already clears illegal_insn, so both bits are needed here
  assign legal = !dec_q.illegal_insn && !dec_kill_q;

  issue_counter #(
    .COUNT_W ( COUNT_W )
  ) issue_counter_i (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .count_i ( count    ),
    .legal_i ( legal    ),
    .count_o ( issued_o )
  );

  assign dec_o = dec_q;

endmodule

// ==== source/decoder.sv ====
// Merges the RV32I and RV32M sub-decoder results into one control struct
// and suppresses the enables of a killed instruction

module decoder import rv_isa_pkg::*, dec_ctrl_pkg::*; #(
  parameter bit M_EXT_EN = 1'b1                    // Build the M decoder
) (
  input  instr_t        instr_i,                   // Held instruction
  input  logic          kill_i,                    // Squash this instruction
  output decoder_ctrl_t ctrl_o                     // Merged control
);

  decoder_ctrl_t i_ctrl;
  decoder_ctrl_t m_ctrl;
  decoder_ctrl_t mux_ctrl;                         // Before kill suppression

  i_decoder i_decoder_i (
    .instr_i ( instr_i ),
    .ctrl_o  ( i_ctrl  )
  );

  generate
    if (M_EXT_EN) begin : g_m_dec
      m_decoder m_decoder_i (
        .instr_i ( instr_i ),
        .ctrl_o  ( m_ctrl  )
      );
    end else begin : g_no_m_dec
      assign m_ctrl = DECODER_CTRL_ILLEGAL;
    end
  endgenerate

  // Priority merge, M first
  always_comb begin
    if (!m_ctrl.illegal_insn) mux_ctrl = m_ctrl;
    else if (!i_ctrl.illegal_insn) mux_ctrl = i_ctrl;
    else mux_ctrl = DECODER_CTRL_ILLEGAL;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Kill suppression
  ////////////////////////////////////////////////////////////////////////////
  // Operation selects and register fields pass through untouched
  always_comb begin
    ctrl_o = mux_ctrl;
    if (kill_i) begin
      ctrl_o.alu_en          = 1'b0;
      ctrl_o.mul_en          = 1'b0;
      ctrl_o.div_en          = 1'b0;
      ctrl_o.lsu_en          = 1'b0;
      ctrl_o.rf_we           = 1'b0;
      ctrl_o.sys_ecall_insn  = 1'b0;
      ctrl_o.sys_ebrk_insn   = 1'b0;
      ctrl_o.sys_mret_insn   = 1'b0;
      ctrl_o.sys_wfi_insn    = 1'b0;
      ctrl_o.sys_fencei_insn = 1'b0;
      ctrl_o.illegal_insn    = 1'b0;               // No trap for a killed word
    end
  end

endmodule

// ==== source/i_decoder.sv ====
// RV32I base instruction decoder, purely combinational
// Unknown encodings, M encodings included, give the illegal control constant

module i_decoder import rv_isa_pkg::*, dec_ctrl_pkg::*; (
  input  instr_t        instr_i,                   // Instruction word
  output decoder_ctrl_t ctrl_o                     // Decoded control
);

  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic          illegal;                          // Set by any unmatched field
  decoder_ctrl_t ctrl;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Shared funct3 table of OP and OP-IMM, the funct7 variants handled by the caller
  function automatic alu_op_e alu_base_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    ctrl              = DECODER_CTRL_ILLEGAL;
    ctrl.illegal_insn = 1'b0;
    ctrl.rd           = instr_i[11:7];             // Fields are extracted for every format
    ctrl.rs1          = instr_i[19:15];
    ctrl.rs2          = instr_i[24:20];
    illegal           = 1'b0;
    case (opcode_e'(instr_i[6:0]))
      OPC_OP: begin
        ctrl.alu_en = 1'b1;
        ctrl.rf_we  = 1'b1;
        ctrl.rf_re  = 2'b11;
        if (funct7 == 7'b0000000) begin
          ctrl.alu_op = alu_base_op(funct3);
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          ctrl.alu_op = ALU_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          ctrl.alu_op = ALU_SRA;
        end else begin
          illegal = 1'b1;                          // Includes funct7 0000001, left to M
        end
      end
      OPC_OP_IMM: begin
        ctrl.alu_en = 1'b1;
        ctrl.rf_we  = 1'b1;
        ctrl.rf_re  = 2'b01;
        ctrl.alu_op = alu_base_op(funct3);
        if (funct3 == 3'b101 && funct7 == 7'b0100000) ctrl.alu_op = ALU_SRA;
        else if (funct3[1:0] == 2'b01 && funct7 != 7'b0000000) illegal = 1'b1;
      end
      OPC_LOAD: begin
        ctrl.lsu_en   = 1'b1;
        ctrl.rf_we    = 1'b1;
        ctrl.rf_re    = 2'b01;
        ctrl.lsu_size = lsu_size_e'(funct3[1:0]);
        ctrl.lsu_sext = ~funct3[2];                // LBU and LHU zero extend
        illegal       = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OPC_STORE: begin
        ctrl.lsu_en   = 1'b1;
        ctrl.lsu_we   = 1'b1;
        ctrl.rf_re    = 2'b11;
        ctrl.lsu_size = lsu_size_e'(funct3[1:0]);
        illegal       = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OPC_BRANCH: begin
        ctrl.alu_en = 1'b1;                        // ALU does the compare
        ctrl.rf_re  = 2'b11;
        case (funct3)
          3'b000:  ctrl.alu_op = ALU_EQ;
          3'b001:  ctrl.alu_op = ALU_NE;
          3'b100:  ctrl.alu_op = ALU_LT;
          3'b101:  ctrl.alu_op = ALU_GE;
          3'b110:  ctrl.alu_op = ALU_LTU;
          3'b111:  ctrl.alu_op = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      OPC_JAL, OPC_LUI, OPC_AUIPC: begin
        ctrl.alu_en = 1'b1;                        // Link value or immediate add
        ctrl.rf_we  = 1'b1;
      end
      OPC_JALR: begin
        ctrl.alu_en = 1'b1;
        ctrl.rf_we  = 1'b1;
        ctrl.rf_re  = 2'b01;
        illegal     = (funct3 != 3'b000);
      end
      OPC_MISC_MEM: begin
        ctrl.sys_fencei_insn = (funct3 == 3'b001);  // Plain FENCE is a no-op here
        illegal              = (funct3[2:1] != 2'b00);
      end
      OPC_SYSTEM: begin
        // Only the funct3 000 group, CSR access is not decoded
        if (funct3 == 3'b000 && instr_i[19:15] == 5'd0 && instr_i[11:7] == 5'd0) begin
          case (instr_i[31:20])
            12'h000: ctrl.sys_ecall_insn = 1'b1;
            12'h001: ctrl.sys_ebrk_insn  = 1'b1;
            12'h302: ctrl.sys_mret_insn  = 1'b1;
            12'h105: ctrl.sys_wfi_insn   = 1'b1;
            default: illegal = 1'b1;
          endcase
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
  end

  assign ctrl_o = illegal ? DECODER_CTRL_ILLEGAL : ctrl;

endmodule

// ==== source/issue_counter.sv ====
// Wrapping counter of legal, unkilled instructions handed to execute
// Advances on the completion strobe of the control FSM

module issue_counter import rv_isa_pkg::*; #(
  parameter int unsigned COUNT_W = COUNT_W_DEF     // Counter width, up to count_t
) (
  input  logic   clk_i,
  input  logic   rst_n_i,                          // Synchronous, active low
  input  logic   count_i,                          // Issue handshake completed
  input  logic   legal_i,                          // Held instruction counts
  output count_t count_o                           // Current count
);

  logic [COUNT_W-1:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (count_i && legal_i) begin
      cnt_q <= cnt_q + COUNT_W'(1);                // Wraps at full scale
    end
  end

  // Zero extended to the shared count type
  assign count_o = count_t'(cnt_q);

endmodule

// ==== source/m_decoder.sv ====
// RV32M multiply/divide decoder, combinational
// Matches only OP with funct7 0000001, everything else is illegal

module m_decoder import rv_isa_pkg::*, dec_ctrl_pkg::*; (
  input  instr_t        instr_i,                   // Instruction word
  output decoder_ctrl_t ctrl_o                     // Decoded control
);

  logic [2:0] funct3;
  logic       is_m;                                // OP major opcode, M funct7

  assign funct3 = instr_i[14:12];
  assign is_m   = (instr_i[6:0] == OPC_OP) && (instr_i[31:25] == 7'b0000001);

  always_comb begin
    ctrl_o = DECODER_CTRL_ILLEGAL;
    if (is_m) begin
      ctrl_o.illegal_insn = 1'b0;
      ctrl_o.rf_we        = 1'b1;
      ctrl_o.rf_re        = 2'b11;                 // Both sources read
      ctrl_o.rd           = instr_i[11:7];
      ctrl_o.rs1          = instr_i[19:15];
      ctrl_o.rs2          = instr_i[24:20];
      if (!funct3[2]) begin                        // funct3 0..3 multiply
        ctrl_o.mul_en = 1'b1;
        ctrl_o.mul_op = mul_op_e'(funct3[1:0]);
      end else begin                               // funct3 4..7 divide / remainder
        ctrl_o.div_en = 1'b1;
        ctrl_o.div_op = div_op_e'(funct3[1:0]);
      end
    end
  end

endmodule

// ==== source/rv_isa_pkg.sv ====
// ISA side of the decode stage: instruction word, register index and operation encodings
// Imported by the decoders, the top level and the issue counter

package rv_isa_pkg;

  parameter int unsigned COUNT_W_DEF = 16;         // Default width of the issue counter

  typedef logic [31:0]            instr_t;         // Raw RV32 instruction word
  typedef logic [4:0]             reg_addr_t;      // x0..x31
  typedef logic [COUNT_W_DEF-1:0] count_t;         // Issued-instruction count

  // Major opcodes, bits [6:0] of the word
  typedef enum logic [6:0] {
    OPC_OP       = 7'b0110011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_BRANCH   = 7'b1100011,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_SYSTEM   = 7'b1110011,
    OPC_MISC_MEM = 7'b0001111
  } opcode_e;

  // ALU operations, arithmetic first, then branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
    ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Follows funct3[1:0] of the M multiply group
  typedef enum logic [1:0] {
    MUL_OP_MUL    = 2'b00,
    MUL_OP_MULH   = 2'b01,
    MUL_OP_MULHSU = 2'b10,
    MUL_OP_MULHU  = 2'b11
  } mul_op_e;

  // Follows funct3[1:0] of the M divide group
  typedef enum logic [1:0] {
    DIV_OP_DIV  = 2'b00,
    DIV_OP_DIVU = 2'b01,
    DIV_OP_REM  = 2'b10,
    DIV_OP_REMU = 2'b11
  } div_op_e;

  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10                               // Same as funct3[1:0] of LW/SW
  } lsu_size_e;

endpackage

// ==== sources.f ====
source/rv_isa_pkg.sv
source/dec_ctrl_pkg.sv
source/i_decoder.sv
source/m_decoder.sv
source/decoder.sv
source/decode_ctrl_fsm.sv
source/issue_counter.sv
source/decode_stage.sv
testbench/tb_clk_gen.sv
testbench/decode_stage_assert.sv
testbench/decode_stage_tb.sv

// ==== testbench/decode_stage_assert.sv ====
// Handshake protocol checks of the decode stage
// Attached to every decode_stage instance by the bind at the end of this file

module decode_stage_assert import dec_ctrl_pkg::*; (
  input logic          clk_i,
  input logic          rst_n_i,
  input logic          instr_req_i,
  input logic          instr_ack_i,
  input logic          dec_req_i,
  input decoder_ctrl_t dec_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Fetch ack only answers a pending request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(instr_ack_i) |-> $past(instr_req_i))
    else $error("instr_ack_o rose while instr_req_i was low");

  // Payload frozen for as long as execute is asked to take it
  dec_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (dec_req_i && $past(dec_req_i)) |-> $stable(dec_i))
    else $error("dec_o changed while dec_req_o was high");

  // One instruction in flight, never both sides open
  one_side_open: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(instr_ack_i && dec_req_i))
    else $error("instr_ack_o and dec_req_o high together");

endmodule

bind decode_stage decode_stage_assert decode_stage_assert_i (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .instr_req_i ( instr_req_i ),
  .instr_ack_i ( instr_ack_o ),
  .dec_req_i   ( dec_req_o   ),
  .dec_i       ( dec_o       )
);

// ==== testbench/decode_stage_tb.sv ====
// Testbench of the decode stage: runs a table of instructions through both handshakes,
// checks each decoded struct against the table and the issue count at the end

module decode_stage_tb import rv_isa_pkg::*, dec_ctrl_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // One table row, expected values after kill suppression
  typedef struct packed {
    instr_t     instr;
    logic       kill;
    logic       illegal;
    logic [5:0] en;                                // alu, mul, div, lsu, lsu_we, rf_we
    alu_op_e    alu_op;
    logic [1:0] md_op;                             // mul_op or div_op, when enabled
    reg_addr_t  rd;
  } case_t;

  logic          clk;
  logic          rst_n;
  logic          instr_req;
  instr_t        instr;
  logic          kill;
  logic          dec_ack;
  logic          instr_ack;
  logic          dec_req;
  decoder_ctrl_t dec;
  count_t        issued;

  case_t       cases[$];
  int unsigned cycles       = 0;
  int unsigned cycle_limit  = 0;                   // Set once the table is built
  int unsigned errors       = 0;
  int unsigned checks       = 0;
  int unsigned issues       = 0;                   // Rising edges of dec_req_o
  int unsigned exp_issued   = 0;
  logic        dec_req_prev = 1'b0;
  logic [31:0] rng          = 32'h7f281581;

  tb_clk_gen clk_gen_i (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  decode_stage #(
    .M_EXT_EN ( 1'b1 ),
    .COUNT_W  ( 16   )
  ) dut (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .instr_req_i ( instr_req ),
    .instr_i     ( instr     ),
    .kill_i      ( kill      ),
    .dec_ack_i   ( dec_ack   ),
    .instr_ack_o ( instr_ack ),
    .dec_req_o   ( dec_req   ),
    .dec_o       ( dec       ),
    .issued_o    ( issued    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);                             // xorshift32
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // R/I/S/B layout: hi = funct7 or imm[11:5], lo = rd or imm[4:0]
  function automatic instr_t encode(input int hi, input int mid, input int rs1,
                                    input int f3, input int lo, input int opc);
    return {7'(hi), 5'(mid), 5'(rs1), 3'(f3), 5'(lo), 7'(opc)};
  endfunction

  task automatic add_case(input instr_t word, input int kill_v, input int ill, input int en,
                          input alu_op_e alu_op, input int md_op, input int rd);
    case_t c;
    c.instr   = word;
    c.kill    = 1'(kill_v);
    c.illegal = 1'(ill);
    c.en      = 6'(en);
    c.alu_op  = alu_op;
    c.md_op   = 2'(md_op);
    c.rd      = 5'(rd);
    cases.push_back(c);
  endtask

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    errors++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////
  task automatic build_table();
    add_case(encode('h00, 2, 1, 0, 3, OPC_OP), 0, 0, 'b100001, ALU_ADD, 0, 3);  // ADD
    add_case(encode('h20, 7, 6, 0, 5, OPC_OP), 0, 0, 'b100001, ALU_SUB, 0, 5);  // SUB
    add_case(encode('h20, 2, 1, 5, 8, OPC_OP), 0, 0, 'b100001, ALU_SRA, 0, 8);  // SRA
    add_case(encode(0, 5, 1, 0, 9, OPC_OP_IMM), 0, 0, 'b100001, ALU_ADD, 0, 9);
    add_case(encode(0, 1, 1, 3, 10, OPC_OP_IMM), 0, 0, 'b100001, ALU_SLTU, 0, 10);
    add_case(encode(0, 4, 2, 2, 11, OPC_LOAD), 0, 0, 'b000101, ALU_ADD, 0, 11);  // LW
    add_case(encode(0, 3, 2, 2, 8, OPC_STORE), 0, 0, 'b000110, ALU_ADD, 0, 8);   // SW
    add_case(encode(0, 2, 1, 1, 4, OPC_BRANCH), 0, 0, 'b100000, ALU_NE, 0, 4);   // BNE
    add_case(encode(0, 0, 0, 0, 0, OPC_SYSTEM), 0, 0, 'b000000, ALU_ADD, 0, 0);  // ECALL
    add_case(encode('h01, 2, 1, 0, 13, OPC_OP), 0, 0, 'b010001, ALU_ADD, 0, 13); // MUL
    add_case(encode('h01, 2, 1, 3, 14, OPC_OP), 0, 0, 'b010001, ALU_ADD, 3, 14); // MULHU
    add_case(encode('h01, 2, 1, 4, 15, OPC_OP), 0, 0, 'b001001, ALU_ADD, 0, 15); // DIV
    add_case(encode('h01, 2, 1, 7, 16, OPC_OP), 0, 0, 'b001001, ALU_ADD, 3, 16); // REMU
    add_case(encode(0, 2, 1, 0, 3, 'h7f), 0, 1, 0, ALU_ADD, 0, 0);              // No opcode
    add_case(encode('h21, 2, 1, 0, 3, OPC_OP), 0, 1, 0, ALU_ADD, 0, 0);
    // Killed words keep their selects and register fields
    add_case(encode(0, 2, 1, 4, 17, OPC_OP), 1, 0, 0, ALU_XOR, 0, 17);          // XOR
    add_case(encode('h21, 2, 1, 0, 3, OPC_OP), 1, 0, 0, ALU_ADD, 0, 0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One instruction through fetch and execute handshakes
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_case(input int idx);
    case_t      c;
    logic [5:0] got_en;
    c = cases[idx];
    instr_req <= 1'b1;
    instr     <= c.instr;
    kill      <= c.kill;
    do @(posedge clk); while (!instr_ack);
    instr_req <= 1'b0;
    instr     <= '1;                               // Captured copy must hold
    do begin
      @(posedge clk);
      if (dec_req && instr_ack) begin
        $display("Entry %0d: dec_req_o rose before instr_ack_o fell", idx);
        errors++;
      end
    end while (instr_ack);
    while (!dec_req) @(posedge clk);

    checks++;
    got_en = {dec.alu_en, dec.mul_en, dec.div_en, dec.lsu_en, dec.lsu_we, dec.rf_we};
    if (dec.illegal_insn !== c.illegal)
      report_value("dec_o.illegal_insn", 32'(dec.illegal_insn), 32'(c.illegal));
    if (got_en !== c.en)
      report_value("dec_o.{alu,mul,div,lsu}_en,lsu_we,rf_we", 32'(got_en), 32'(c.en));
    if (dec.alu_op !== c.alu_op)
      report_value("dec_o.alu_op", 32'(dec.alu_op), 32'(c.alu_op));
    if (c.en[4] && dec.mul_op !== c.md_op)
      report_value("dec_o.mul_op", 32'(dec.mul_op), 32'(c.md_op));
    if (c.en[3] && dec.div_op !== c.md_op)
      report_value("dec_o.div_op", 32'(dec.div_op), 32'(c.md_op));
    if (dec.rd !== c.rd)
      report_value("dec_o.rd", 32'(dec.rd), 32'(c.rd));

    rng = next_rand(rng);
    repeat (rng[1:0]) @(posedge clk);              // 0..3 cycles of back-pressure
    dec_ack <= 1'b1;
    do @(posedge clk); while (dec_req);
    dec_ack <= 1'b0;
    if (int'(issues) != idx + 1) begin
      $display("Entry %0d: %0d issues seen so far, expected %0d", idx, issues, idx + 1);
      errors++;
    end
  endtask

  // Counts issues as seen by execute, one per dec_req_o rise
  always @(posedge clk) begin
    dec_req_prev <= dec_req;
    if (dec_req && !dec_req_prev) issues <= issues + 1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    instr_req = 1'b0;
    instr     = '0;
    kill      = 1'b0;
    dec_ack   = 1'b0;
    build_table();
    cycle_limit = 40 * cases.size();
    while (rst_n !== 1'b1) @(posedge clk);
    foreach (cases[i]) run_case(i);

    foreach (cases[i]) begin
      if (!cases[i].kill && !cases[i].illegal) exp_issued++;
    end
    repeat (2) @(posedge clk);
    checks++;
    if (issued !== count_t'(exp_issued))
      report_value("issued_o", 32'(issued), exp_issued);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_clk_gen.sv ====
// Clock and reset source of the testbench: 4 ns clock, reset held low for 3 cycles

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o                             // Synchronous, active low
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;                     // 4 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;                               // Released on the third edge
  end

endmodule
